// File: dv/x86_opnd_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "x86_opnd_cfg.svh"

module x86_opnd_tb;

  import x86_opnd_pkg::*;

  // Expected content of one slot, a register index or a literal
  typedef struct packed {
    logic    is_reg;
    regsel_t idx;
    gpr_t    lit;
  } slot_exp_t;

  // One table step, either a register write or a decode
  typedef struct {
    string        name;
    bit           is_write;
    regsel_t      wb_sel;
    gpr_t         wb_data;
    opnd_form_t   form;
    instr_bytes_t instr;
    bit           imm_1byte;
    bit           p16;
    bit           a16;
    opnd_count_t  count;
    bit           mem;
    slot_exp_t    s0;
    slot_exp_t    s1;
    slot_exp_t    s2;
  } row_t;

  logic         clk;
  logic         rst;
  logic         decode_valid;
  instr_bytes_t instr;
  opnd_form_t   opnd_form;
  logic         imm_1byte;
  logic         prefix_operand_16bit;
  logic         prefix_address_16bit;
  logic         wb_en;
  regsel_t      wb_sel;
  gpr_t         wb_data;
  logic         opnd_valid;
  opnd_result_t result;

  int           seed = 61054;
  int           errors = 0;
  int           checks = 0;
  int           cycles = 0;
  logic         prev_strobe = 1'b0;
  // Testbench copy of the register file
  gpr_t         model [8];
  row_t         rows [$];
  opnd_result_t exp_q [$];
  string        name_q [$];

  x86_opnd_stage x86_opnd_stage_i (
    .clk                  (clk),
    .rst                  (rst),
    .decode_valid         (decode_valid),
    .instr                (instr),
    .opnd_form            (opnd_form),
    .imm_1byte            (imm_1byte),
    .prefix_operand_16bit (prefix_operand_16bit),
    .prefix_address_16bit (prefix_address_16bit),
    .wb_en                (wb_en),
    .wb_sel               (wb_sel),
    .wb_data              (wb_data),
    .opnd_valid           (opnd_valid),
    .result               (result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic slot_exp_t reg_slot(input regsel_t idx);
    return '{is_reg: 1'b1, idx: idx, lit: '0};
  endfunction

  function automatic slot_exp_t lit_slot(input gpr_t val);
    return '{is_reg: 1'b0, idx: '0, lit: val};
  endfunction

  // Register operands shrink to 16 bits, zero-extended, under the size prefix
  function automatic gpr_t slot_value(input slot_exp_t s, input bit p16);
    gpr_t v;
    if (!s.is_reg) begin
      return s.lit;
    end
    v = model[s.idx];
    if (p16) begin
      v = {16'h0000, v[15:0]};
    end
    return v;
  endfunction

  task automatic add_row(input string name, input opnd_form_t form, input instr_bytes_t ib,
                         input bit imm1, input bit p16, input bit a16,
                         input opnd_count_t count, input bit mem,
                         input slot_exp_t s0, input slot_exp_t s1, input slot_exp_t s2);
    row_t r;
    r.name      = name;
    r.is_write  = 1'b0;
    r.form      = form;
    r.instr     = ib;
    r.imm_1byte = imm1;
    r.p16       = p16;
    r.a16       = a16;
    r.count     = count;
    r.mem       = mem;
    r.s0        = s0;
    r.s1        = s1;
    r.s2        = s2;
    rows.push_back(r);
  endtask

  task automatic add_write(input regsel_t sel, input gpr_t data);
    row_t r;
    r.name     = "write";
    r.is_write = 1'b1;
    r.wb_sel   = sel;
    r.wb_data  = data;
    rows.push_back(r);
  endtask

  task automatic build_table();
    slot_exp_t z;
    z = lit_slot('0);
    // Register to register
    add_row("rm_reg_11", `OPND_ENC_MODREGRM_RM_REG, 72'hC301, 0, 0, 0, 2, 0,
            reg_slot(3), reg_slot(0), z);
    add_row("reg_rm_11", `OPND_ENC_MODREGRM_REG_RM, 72'hCE8B, 0, 0, 0, 2, 0,
            reg_slot(1), reg_slot(6), z);
    add_row("eax_reg", `OPND_ENC_EAX_REG, 72'h97, 0, 0, 0, 2, 0,
            reg_slot(0), reg_slot(7), z);
    // Immediates from byte 1 and byte 2, three sizes
    add_row("imm8_neg", `OPND_ENC_IMM, 72'h806A, 1, 0, 0, 1, 0,
            lit_slot(32'hFFFFFF80), z, z);
    add_row("reg_imm32", `OPND_ENC_REG_IMM, 72'h89ABCDEFBA, 0, 0, 0, 2, 0,
            reg_slot(2), lit_slot(32'h89ABCDEF), z);
    add_row("eax_imm16", `OPND_ENC_EAX_IMM, 72'h800105, 0, 1, 0, 2, 0,
            reg_slot(0), lit_slot(32'hFFFF8001), z);
    add_row("rm_imm8", `OPND_ENC_MODREGRM_RM_IMM, 72'h7FC583, 1, 0, 0, 2, 0,
            reg_slot(5), lit_slot(32'h0000007F), z);
    add_row("reg_rm_imm32", `OPND_ENC_MODREGRM_REG_RM_IMM, 72'hFEDCBA98D469, 0, 0, 0, 3, 0,
            reg_slot(2), reg_slot(4), lit_slot(32'hFEDCBA98));
    add_row("rm_imm16", `OPND_ENC_MODREGRM_RM_IMM, 72'h1234C281, 0, 1, 0, 2, 0,
            reg_slot(2), lit_slot(32'h00001234), z);
    add_row("reg_rm_p16", `OPND_ENC_MODREGRM_REG_RM, 72'hDF8B, 0, 1, 0, 2, 0,
            reg_slot(3), reg_slot(7), z);
    // Double shift, count in CL
    add_row("rm_reg_cl", `OPND_ENC_MODREGRM_RM_REG_CL, 72'hF0A5, 0, 0, 0, 3, 0,
            reg_slot(0), reg_slot(6), reg_slot(1));
    // Memory r/m: flag only, slot stays zero
    add_row("rm_mem_disp8", `OPND_ENC_MODREGRM_RM_REG, 72'h104589, 0, 0, 1, 2, 1,
            z, reg_slot(0), z);
    add_row("rm_sib", `OPND_ENC_MODREGRM_RM, 72'h2434FF, 0, 0, 0, 1, 1, z, z, z);
    add_row("rm_reg_imm_mem", `OPND_ENC_MODREGRM_RM_REG_IMM, 72'h0503A4, 1, 0, 0, 3, 1,
            z, reg_slot(0), lit_slot(32'h00000005));
    add_row("none", `OPND_ENC_NONE, 72'h90, 0, 0, 0, 0, 0, z, z, z);
    // EBX rewritten right before two back-to-back decodes
    add_write(3'd3, 32'hCAFEF00D);
    add_row("after_wb", `OPND_ENC_MODREGRM_RM_REG, 72'hD901, 0, 0, 0, 2, 0,
            reg_slot(1), reg_slot(3), z);
    add_row("after_wb_p16", `OPND_ENC_REG, 72'h53, 0, 1, 0, 1, 0, reg_slot(3), z, z);
  endtask

  // Expected result built from the table and the register copy
  task automatic drive_row(input row_t r);
    opnd_result_t exp_val;
    exp_val.opnd0      = slot_value(r.s0, r.p16);
    exp_val.opnd1      = slot_value(r.s1, r.p16);
    exp_val.opnd2      = slot_value(r.s2, r.p16);
    exp_val.opnd_count = r.count;
    exp_val.mem_opnd   = r.mem;
    decode_valid         <= 1'b1;
    instr                <= r.instr;
    opnd_form            <= r.form;
    imm_1byte            <= r.imm_1byte;
    prefix_operand_16bit <= r.p16;
    prefix_address_16bit <= r.a16;
    exp_q.push_back(exp_val);
    name_q.push_back(r.name);
  endtask

  task automatic check_opnd(input string name, input gpr_t exp_val, input gpr_t act);
    checks++;
    if (act !== exp_val) begin
      errors++;
      $display("Mismatch %s: expected %08h, actual %08h", name, exp_val, act);
    end
  endtask

  task automatic check_count(input string name, input opnd_count_t exp_val,
                             input opnd_count_t act);
    checks++;
    if (act !== exp_val) begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp_val, act);
    end
  endtask

  task automatic check_flag(input string name, input bit exp_val, input bit act);
    checks++;
    if (act !== exp_val) begin
      errors++;
      $display("Mismatch %s: expected %0b, actual %0b", name, exp_val, act);
    end
  endtask

  // Outputs settle after the capturing edge, so sample on the falling edge
  always @(negedge clk) begin : monitor
    opnd_result_t exp_val;
    string        name;
    if (rst) begin
      prev_strobe = 1'b0;
    end else begin
      if (prev_strobe) begin
        exp_val = exp_q.pop_front();
        name    = name_q.pop_front();
        if (!opnd_valid) begin
          errors++;
          $display("No opnd_valid pulse one cycle after the strobe of %s", name);
        end else begin
          check_opnd({name, ".opnd0"}, exp_val.opnd0, result.opnd0);
          check_opnd({name, ".opnd1"}, exp_val.opnd1, result.opnd1);
          check_opnd({name, ".opnd2"}, exp_val.opnd2, result.opnd2);
          check_count({name, ".opnd_count"}, exp_val.opnd_count, result.opnd_count);
          check_flag({name, ".mem_opnd"}, exp_val.mem_opnd, result.mem_opnd);
        end
      end else if (opnd_valid) begin
        errors++;
        $display("opnd_valid pulsed without a decode strobe the cycle before");
      end
      prev_strobe = decode_valid;
    end
  end

  // Reset, preload, table, then every row once more as slack
  always @(posedge clk) begin
    cycles++;
    if (cycles > 8 + 8 + 2 * rows.size() + 20) begin
      $display("Run did not finish within %0d cycles", cycles - 1);
      $display("Checks: %0d  Errors: %0d", checks, errors);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin : driver
    gpr_t v;
    rst                  = 1'b1;
    decode_valid         = 1'b0;
    instr                = '0;
    opnd_form            = '0;
    imm_1byte            = 1'b0;
    prefix_operand_16bit = 1'b0;
    prefix_address_16bit = 1'b0;
    wb_en                = 1'b0;
    wb_sel               = '0;
    wb_data              = '0;
    build_table();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag("reset.opnd_valid", 1'b0, opnd_valid);
    check_opnd("reset.opnd0", '0, result.opnd0);
    check_opnd("reset.opnd1", '0, result.opnd1);
    check_opnd("reset.opnd2", '0, result.opnd2);
    check_count("reset.opnd_count", '0, result.opnd_count);
    check_flag("reset.mem_opnd", 1'b0, result.mem_opnd);
    // Preload EAX..EDI through the writeback port
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      v        = $random(seed);
      model[i] = v;
      wb_en   <= 1'b1;
      wb_sel  <= regsel_t'(i);
      wb_data <= v;
    end
    @(posedge clk);
    wb_en <= 1'b0;
    foreach (rows[i]) begin
      @(posedge clk);
      if (rows[i].is_write) begin
        decode_valid           <= 1'b0;
        wb_en                  <= 1'b1;
        wb_sel                 <= rows[i].wb_sel;
        wb_data                <= rows[i].wb_data;
        model[rows[i].wb_sel]  = rows[i].wb_data;
      end else begin
        wb_en <= 1'b0;
        drive_row(rows[i]);
      end
    end
    @(posedge clk);
    decode_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // One more cycle to catch a stray pulse
    @(negedge clk);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/x86_opnd_pkg.sv
verilog/gpr_file.sv
verilog/opnd_form_decode.sv
verilog/opnd_lane.sv
verilog/opnd_stage_reg.sv
verilog/x86_opnd_stage.sv
dv/x86_opnd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the operand-fetch stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module x86_opnd_tb \
  -Mdir obj_dir -o x86_opnd_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/x86_opnd_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

// File: verilog/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_en,
  input  x86_opnd_pkg::regsel_t   wb_sel,
  input  x86_opnd_pkg::gpr_t      wb_data,
  output x86_opnd_pkg::gpr_bank_t gpr_bank
);

  import x86_opnd_pkg::*;

  // Architectural registers EAX..EDI
  gpr_t regs [8];

  // One write per cycle, visible to decode from the next cycle on
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_sel] <= wb_data;
    end
  end

  // Flatten into one bank so every lane reads in parallel
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      gpr_bank[i*32 +: 32] = regs[i];
    end
  end

  // Writeback source must give a known index with every write
  wb_sel_known_a : assert property (
    @(posedge clk) disable iff (rst)
    wb_en |-> !$isunknown(wb_sel)
  ) else $error("writeback index unknown during write");

endmodule

`default_nettype wire

// File: verilog/opnd_form_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "x86_opnd_cfg.svh"

module opnd_form_decode (
  input  logic                       decode_valid,
  input  x86_opnd_pkg::instr_bytes_t instr,
  input  x86_opnd_pkg::opnd_form_t   opnd_form,
  input  logic                       imm_1byte,
  input  logic                       prefix_operand_16bit,
  input  logic                       prefix_address_16bit,
  output x86_opnd_pkg::opnd_sel_t    opnd_sel [`OPND_LANES],
  output x86_opnd_pkg::gpr_t         imm_val,
  output x86_opnd_pkg::opnd_count_t  opnd_count,
  output logic                       mem_opnd
);

  import x86_opnd_pkg::*;

  logic [7:0] modrm;
  logic       mod_direct;
  logic       has_modrm;
  logic       has_imm;
  logic       has_sib;
  gpr_t       imm_raw;
  opnd_sel_t  sel_none;
  opnd_sel_t  sel_imm;
  opnd_sel_t  sel_opc;
  opnd_sel_t  sel_rm;
  opnd_sel_t  sel_reg;
  opnd_sel_t  sel_eax;
  opnd_sel_t  sel_ecx;

  // ModR/M always follows the opcode byte
  assign modrm      = instr[15:8];
  assign mod_direct = (modrm[7:6] == 2'b11);

  // Every form from RM up to REG_RM_IMM carries a ModR/M byte
  assign has_modrm = (opnd_form >= `OPND_ENC_MODREGRM_RM) &&
                     (opnd_form <= `OPND_ENC_LAST);

  assign has_imm = (opnd_form == `OPND_ENC_IMM) ||
                   (opnd_form == `OPND_ENC_REG_IMM) ||
                   (opnd_form == `OPND_ENC_EAX_IMM) ||
                   (opnd_form == `OPND_ENC_MODREGRM_RM_IMM) ||
                   (opnd_form == `OPND_ENC_MODREGRM_RM_REG_IMM) ||
                   (opnd_form == `OPND_ENC_MODREGRM_REG_RM_IMM);

  // SIB only exists with 32-bit addressing, a memory mod and rm = 100
  assign has_sib = has_modrm && !prefix_address_16bit &&
                   !mod_direct && (modrm[2:0] == 3'b100);

  // r/m names a memory location unless mod = 11
  assign mem_opnd = (has_modrm && !mod_direct) || has_sib;

  // Immediate begins right after the opcode or after ModR/M
  assign imm_raw = has_modrm ? instr[47:16] : instr[39:8];

  always_comb begin
    if (!has_imm) begin
      imm_val = '0;
    end else if (imm_1byte) begin
      imm_val = {{24{imm_raw[7]}}, imm_raw[7:0]};
    end else if (prefix_operand_16bit) begin
      imm_val = {{16{imm_raw[15]}}, imm_raw[15:0]};
    end else begin
      imm_val = imm_raw;
    end
  end

  // Candidate selectors, picked per slot below
  assign sel_none = '{src: `OPND_SRC_NONE, regsel: '0};
  assign sel_imm  = '{src: `OPND_SRC_IMM, regsel: '0};
  assign sel_opc  = '{src: `OPND_SRC_REG, regsel: instr[2:0]};
  assign sel_reg  = '{src: `OPND_SRC_REG, regsel: modrm[5:3]};
  assign sel_eax  = '{src: `OPND_SRC_REG, regsel: `REG_EAX};
  assign sel_ecx  = '{src: `OPND_SRC_REG, regsel: `REG_ECX};
  // Memory r/m yields no value here, only the flag
  assign sel_rm   = mod_direct ? opnd_sel_t'{src: `OPND_SRC_REG, regsel: modrm[2:0]} :
                                 sel_none;

  always_comb begin
    opnd_sel[0] = sel_none;
    opnd_sel[1] = sel_none;
    opnd_sel[2] = sel_none;
    opnd_count  = 2'd0;
    case (opnd_form)
      `OPND_ENC_IMM: begin
        opnd_sel[0] = sel_imm;
        opnd_count  = 2'd1;
      end
      `OPND_ENC_REG: begin
        opnd_sel[0] = sel_opc;
        opnd_count  = 2'd1;
      end
      `OPND_ENC_REG_IMM: begin
        opnd_sel[0] = sel_opc;
        opnd_sel[1] = sel_imm;
        opnd_count  = 2'd2;
      end
      `OPND_ENC_EAX_IMM: begin
        opnd_sel[0] = sel_eax;
        opnd_sel[1] = sel_imm;
        opnd_count  = 2'd2;
      end
      // Second register sits in the opcode, as in xchg eax, r32
      `OPND_ENC_EAX_REG: begin
        opnd_sel[0] = sel_eax;
        opnd_sel[1] = sel_opc;
        opnd_count  = 2'd2;
      end
      `OPND_ENC_MODREGRM_RM: begin
        opnd_sel[0] = sel_rm;
        opnd_count  = 2'd1;
      end
      `OPND_ENC_MODREGRM_RM_IMM: begin
        opnd_sel[0] = sel_rm;
        opnd_sel[1] = sel_imm;
        opnd_count  = 2'd2;
      end
      `OPND_ENC_MODREGRM_RM_REG: begin
        opnd_sel[0] = sel_rm;
        opnd_sel[1] = sel_reg;
        opnd_count  = 2'd2;
      end
      `OPND_ENC_MODREGRM_RM_REG_IMM: begin
        opnd_sel[0] = sel_rm;
        opnd_sel[1] = sel_reg;
        opnd_sel[2] = sel_imm;
        opnd_count  = 2'd3;
      end
      // Double shifts take their count from CL
      `OPND_ENC_MODREGRM_RM_REG_CL: begin
        opnd_sel[0] = sel_rm;
        opnd_sel[1] = sel_reg;
        opnd_sel[2] = sel_ecx;
        opnd_count  = 2'd3;
      end
      `OPND_ENC_MODREGRM_REG_RM: begin
        opnd_sel[0] = sel_reg;
        opnd_sel[1] = sel_rm;
        opnd_count  = 2'd2;
      end
      `OPND_ENC_MODREGRM_REG_RM_IMM: begin
        opnd_sel[0] = sel_reg;
        opnd_sel[1] = sel_rm;
        opnd_sel[2] = sel_imm;
        opnd_count  = 2'd3;
      end
      // NONE and reserved codes give no operands
      default: begin
        opnd_count = 2'd0;
      end
    endcase
  end

  // Upstream decoder must never hand over a reserved form
  always_comb begin
    if (decode_valid) begin
      form_known_a : assert (opnd_form <= `OPND_ENC_LAST)
        else $error("reserved operand form %0d", opnd_form);
    end
  end

endmodule

`default_nettype wire

// File: verilog/opnd_lane.sv
`timescale 1ns/1ps
`default_nettype none
`include "x86_opnd_cfg.svh"

module opnd_lane (
  input  x86_opnd_pkg::opnd_sel_t sel,
  input  x86_opnd_pkg::gpr_bank_t gpr_bank,
  input  x86_opnd_pkg::gpr_t      imm_val,
  input  logic                    prefix_operand_16bit,
  output x86_opnd_pkg::gpr_t      opnd_val
);

  import x86_opnd_pkg::*;

  gpr_t reg_val;
  gpr_t reg_sized;

  // Index times 32 picks the register out of the bank
  assign reg_val = gpr_bank[{sel.regsel, 5'd0} +: 32];

  // 16-bit operand size keeps only AX..DI
  assign reg_sized = prefix_operand_16bit ? {16'd0, reg_val[15:0]} : reg_val;

  always_comb begin
    case (sel.src)
      `OPND_SRC_REG: opnd_val = reg_sized;
      // Immediate arrives already sign-extended
      `OPND_SRC_IMM: opnd_val = imm_val;
      // Empty slot or memory operand
      default:       opnd_val = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/opnd_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "x86_opnd_cfg.svh"

module opnd_stage_reg (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         decode_valid,
  input  x86_opnd_pkg::gpr_t           opnd_val [`OPND_LANES],
  input  x86_opnd_pkg::opnd_count_t    opnd_count,
  input  logic                         mem_opnd,
  output logic                         opnd_valid,
  output x86_opnd_pkg::opnd_result_t   result
);

  import x86_opnd_pkg::*;

  opnd_result_t result_d;

  // Gather the three lanes and the decode flags
  always_comb begin
    result_d.opnd0      = opnd_val[0];
    result_d.opnd1      = opnd_val[1];
    result_d.opnd2      = opnd_val[2];
    result_d.opnd_count = opnd_count;
    result_d.mem_opnd   = mem_opnd;
  end

  // Result holds between strobes, valid is a single-cycle pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      opnd_valid <= 1'b0;
      result     <= '0;
    end else begin
      opnd_valid <= decode_valid;
      if (decode_valid) begin
        result <= result_d;
      end
    end
  end

  // Each strobe must hand over fully resolved operands
  capture_known_a : assert property (
    @(posedge clk) disable iff (rst)
    decode_valid |-> !$isunknown(result_d)
  ) else $error("unknown operand data captured with decode_valid");

endmodule

`default_nettype wire

// File: verilog/x86_opnd_cfg.svh
`ifndef X86_OPND_CFG_SVH
`define X86_OPND_CFG_SVH

// Operand-encoding form codes, one per instruction class
`define OPND_ENC_NONE                  4'd0
`define OPND_ENC_IMM                   4'd1
// Register in the low three opcode bits
`define OPND_ENC_REG                   4'd2
`define OPND_ENC_REG_IMM               4'd3
// Implicit EAX as operand 0
`define OPND_ENC_EAX_IMM               4'd4
`define OPND_ENC_EAX_REG               4'd5

// ModR/M forms with r/m as operand 0
`define OPND_ENC_MODREGRM_RM           4'd6
`define OPND_ENC_MODREGRM_RM_IMM       4'd7
`define OPND_ENC_MODREGRM_RM_REG       4'd8
`define OPND_ENC_MODREGRM_RM_REG_IMM   4'd9
`define OPND_ENC_MODREGRM_RM_REG_CL    4'd10
// ModR/M forms with reg as operand 0
`define OPND_ENC_MODREGRM_REG_RM       4'd11
`define OPND_ENC_MODREGRM_REG_RM_IMM   4'd12
// Highest code in use, 13 to 15 are reserved
`define OPND_ENC_LAST                  4'd12

// Source kind of one operand slot
`define OPND_SRC_NONE                  2'd0
`define OPND_SRC_REG                   2'd1
`define OPND_SRC_IMM                   2'd2

// Register indices of the implicit operands
`define REG_EAX                        3'd0
`define REG_ECX                        3'd1

// Operand slots per instruction
`define OPND_LANES                     3

`endif

// File: verilog/x86_opnd_pkg.sv
`default_nettype none

package x86_opnd_pkg;

  // First nine instruction bytes, opcode in bits 7:0
  typedef logic [71:0] instr_bytes_t;

  // One register or operand value
  typedef logic [31:0] gpr_t;

  // EAX in bits 31:0 up to EDI in bits 255:224
  typedef logic [255:0] gpr_bank_t;

  // Register index
  typedef logic [2:0] regsel_t;

  // Operand-encoding form code
  typedef logic [3:0] opnd_form_t;

  // Source kind: none, register or immediate
  typedef logic [1:0] opnd_src_t;

  // Operand count, 0 to 3
  typedef logic [1:0] opnd_count_t;

  // Selector for one operand slot
  typedef struct packed {
    opnd_src_t src;
    regsel_t   regsel;
  } opnd_sel_t;

  // Registered stage output
  // opnd0 sits in the low word
  typedef struct packed {
    logic        mem_opnd;
    opnd_count_t opnd_count;
    gpr_t        opnd2;
    gpr_t        opnd1;
    gpr_t        opnd0;
  } opnd_result_t;

endpackage

`default_nettype wire

// File: verilog/x86_opnd_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "x86_opnd_cfg.svh"

module x86_opnd_stage (
  input  logic                       clk,
  input  logic                       rst,
  // Decode side
  input  logic                       decode_valid,
  input  x86_opnd_pkg::instr_bytes_t instr,
  input  x86_opnd_pkg::opnd_form_t   opnd_form,
  input  logic                       imm_1byte,
  input  logic                       prefix_operand_16bit,
  input  logic                       prefix_address_16bit,
  // Writeback side
  input  logic                       wb_en,
  input  x86_opnd_pkg::regsel_t      wb_sel,
  input  x86_opnd_pkg::gpr_t         wb_data,
  // Registered operands
  output logic                       opnd_valid,
  output x86_opnd_pkg::opnd_result_t result
);

  import x86_opnd_pkg::*;

  gpr_bank_t   gpr_bank;
  opnd_sel_t   opnd_sel [`OPND_LANES];
  gpr_t        imm_val;
  opnd_count_t opnd_count;
  logic        mem_opnd;
  gpr_t        opnd_val [`OPND_LANES];

  gpr_file gpr_file_i (
    .clk      (clk),
    .rst      (rst),
    .wb_en    (wb_en),
    .wb_sel   (wb_sel),
    .wb_data  (wb_data),
    .gpr_bank (gpr_bank)
  );

  opnd_form_decode opnd_form_decode_i (
    .decode_valid         (decode_valid),
    .instr                (instr),
    .opnd_form            (opnd_form),
    .imm_1byte            (imm_1byte),
    .prefix_operand_16bit (prefix_operand_16bit),
    .prefix_address_16bit (prefix_address_16bit),
    .opnd_sel             (opnd_sel),
    .imm_val              (imm_val),
    .opnd_count           (opnd_count),
    .mem_opnd             (mem_opnd)
  );

  // One lane per operand slot, all reading the same bank
  for (genvar k = 0; k < `OPND_LANES; k++) begin : g_lane
    opnd_lane opnd_lane_i (
      .sel                  (opnd_sel[k]),
      .gpr_bank             (gpr_bank),
      .imm_val              (imm_val),
      .prefix_operand_16bit (prefix_operand_16bit),
      .opnd_val             (opnd_val[k])
    );
  end

  opnd_stage_reg opnd_stage_reg_i (
    .clk          (clk),
    .rst          (rst),
    .decode_valid (decode_valid),
    .opnd_val     (opnd_val),
    .opnd_count   (opnd_count),
    .mem_opnd     (mem_opnd),
    .opnd_valid   (opnd_valid),
    .result       (result)
  );

endmodule

`default_nettype wire
